// ==== src/soc_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// SoC package
// Address map, bus types, widths and device indices
// shared by the interconnect and the devices
// ~~~~~~~~~~~~~~~~~~~~

package soc_pkg;

  // Bus widths
  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_strb_t;

  typedef struct packed {
    logic      valid;  // Request strobe
    logic      we;
    bus_addr_t addr;
    bus_strb_t be;
    bus_data_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic      valid;  // One-cycle response pulse
    logic      err;
    bus_data_t rdata;
  } bus_rsp_t;

  // Devices behind the interconnect
  localparam int NrDevices = 3;
  localparam int DevRam    = 0;
  localparam int DevTimer  = 1;
  localparam int DevPwm    = 2;

  typedef logic [$clog2(NrDevices)-1:0] dev_idx_t;

  // Address regions, masks follow from the sizes
  localparam bus_addr_t MemSize    = 32'd4096;
  localparam bus_addr_t MemStart   = 32'h0010_0000;
  localparam bus_addr_t MemMask    = ~(MemSize - 1);
  localparam bus_addr_t TimerSize  = 32'd4096;
  localparam bus_addr_t TimerStart = 32'h8000_2000;
  localparam bus_addr_t TimerMask  = ~(TimerSize - 1);
  localparam bus_addr_t PwmSize    = 32'd4096;
  localparam bus_addr_t PwmStart   = 32'h8000_3000;
  localparam bus_addr_t PwmMask    = ~(PwmSize - 1);

  localparam int MemWords = int'(MemSize / 4);

  // Decode table, indexed by device
  localparam bus_addr_t [NrDevices-1:0] DevBase = {PwmStart, TimerStart, MemStart};
  localparam bus_addr_t [NrDevices-1:0] DevMask = {PwmMask, TimerMask, MemMask};

  // Timer
  typedef logic [63:0] timer_val_t;
  localparam bus_addr_t TimerMtimeLo = 32'h0;
  localparam bus_addr_t TimerMtimeHi = 32'h4;
  localparam bus_addr_t TimerCmpLo   = 32'h8;
  localparam bus_addr_t TimerCmpHi   = 32'hC;

  // PWM, duty n sits at 4 * (n + 1)
  localparam int        PwmWidth     = 12;
  localparam int        PwmCtrSize   = 8;
  localparam bus_addr_t PwmPeriodOff = 32'h0;

  typedef logic [PwmCtrSize-1:0] pwm_cnt_t;
  typedef logic [PwmWidth-1:0]   pwm_out_t;

  // Merge the enabled bytes of a write into the old word
  function automatic bus_data_t apply_be(bus_data_t old_val, bus_data_t new_val, bus_strb_t be);
    bus_data_t res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[b*8 +: 8] = new_val[b*8 +: 8];
    end
    return res;
  endfunction

endpackage

// ==== src/soc_bus_xbar.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Bus interconnect
// Base/mask decode of the host address, fan-out to one device,
// registered select for the response path
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module soc_bus_xbar import soc_pkg::*; (
  input  logic     clk_sys_i,
  input  logic     rst_sys_ni,

  input  bus_req_t host_req_i,
  output bus_rsp_t host_rsp_o,

  output bus_req_t dev_req_o [NrDevices],
  input  bus_rsp_t dev_rsp_i [NrDevices]
);

  logic [NrDevices-1:0] match;
  logic [NrDevices-1:0] dev_valid;
  dev_idx_t             sel_d;
  dev_idx_t             sel_q;
  logic                 hit_q;   // Mapped request last cycle
  logic                 miss_q;  // Unmapped request last cycle

  // Address decode
  always_comb begin
    sel_d = '0;
    for (int i = 0; i < NrDevices; i++) begin
      match[i] = (host_req_i.addr & DevMask[i]) == DevBase[i];
      if (match[i]) sel_d = dev_idx_t'(i);
    end
  end

  assign dev_valid = match & {NrDevices{host_req_i.valid}};

  // Same payload to every device but the strobe only to the hit one
  always_comb begin
    for (int i = 0; i < NrDevices; i++) begin
      dev_req_o[i]       = host_req_i;
      dev_req_o[i].valid = dev_valid[i];
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      hit_q  <= 1'b0;
      miss_q <= 1'b0;
      sel_q  <= '0;
    end else begin
      hit_q  <= host_req_i.valid & (|match);
      miss_q <= host_req_i.valid & ~(|match);
      sel_q  <= sel_d;
    end
  end

  // Response mux
  always_comb begin
    host_rsp_o = '0;
    if (miss_q) begin
      host_rsp_o.valid = 1'b1;  // Error with zero data
      host_rsp_o.err   = 1'b1;
    end else if (hit_q) begin
      host_rsp_o = dev_rsp_i[sel_q];
    end
  end

  // Regions must not overlap
  a_dev_onehot: assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni) $onehot0(dev_valid)
  ) else $error("More than one device selected");

  // Every device has to answer after exactly one cycle
  a_rsp_latency: assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_req_i.valid |=> host_rsp_o.valid
  ) else $error("Missing response one cycle after request");

endmodule

// ==== src/soc_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Data RAM
// Single-port word memory with byte enables, one-cycle read
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module soc_ram import soc_pkg::*; (
  input  logic     clk_sys_i,
  input  logic     rst_sys_ni,

  input  bus_req_t req_i,
  output bus_rsp_t rsp_o
);

  bus_data_t                    mem_q [MemWords];
  bus_addr_t                    offset;
  logic [$clog2(MemWords)-1:0]  word_idx;
  logic                         valid_q;
  bus_data_t                    rdata_q;

  assign offset   = req_i.addr & ~MemMask;
  assign word_idx = offset[$clog2(MemWords)+1:2];  // Drop byte lane bits

  always_ff @(posedge clk_sys_i) begin
    if (req_i.valid && req_i.we) begin
      mem_q[word_idx] <= apply_be(mem_q[word_idx], req_i.wdata, req_i.be);
    end
  end

  // Read data, zero on writes
  always_ff @(posedge clk_sys_i) begin
    if (req_i.valid) begin
      rdata_q <= req_i.we ? '0 : mem_q[word_idx];
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
    end
  end

  assign rsp_o = '{valid: valid_q, err: 1'b0, rdata: rdata_q};

endmodule

// ==== src/soc_timer.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Timer
// Free-running 64-bit time with a compare value,
// interrupt while time has reached compare
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module soc_timer import soc_pkg::*; (
  input  logic     clk_sys_i,
  input  logic     rst_sys_ni,

  input  bus_req_t req_i,
  output bus_rsp_t rsp_o,

  output logic     timer_irq_o
);

  timer_val_t mtime_q;
  timer_val_t mtimecmp_q;
  bus_addr_t  offset;
  logic       wr;
  logic       valid_q;
  bus_data_t  rdata_d;
  bus_data_t  rdata_q;

  assign offset = req_i.addr & ~TimerMask;
  assign wr     = req_i.valid & req_i.we;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;  // Far future, irq low
    end else begin
      // Counter holds for one cycle when software writes it
      if (wr && offset == TimerMtimeLo) begin
        mtime_q[31:0] <= apply_be(mtime_q[31:0], req_i.wdata, req_i.be);
      end else if (wr && offset == TimerMtimeHi) begin
        mtime_q[63:32] <= apply_be(mtime_q[63:32], req_i.wdata, req_i.be);
      end else begin
        mtime_q <= mtime_q + 64'd1;
      end

      if (wr && offset == TimerCmpLo) begin
        mtimecmp_q[31:0] <= apply_be(mtimecmp_q[31:0], req_i.wdata, req_i.be);
      end
      if (wr && offset == TimerCmpHi) begin
        mtimecmp_q[63:32] <= apply_be(mtimecmp_q[63:32], req_i.wdata, req_i.be);
      end
    end
  end

  always_comb begin
    case (offset)
      TimerMtimeLo: rdata_d = mtime_q[31:0];
      TimerMtimeHi: rdata_d = mtime_q[63:32];
      TimerCmpLo:   rdata_d = mtimecmp_q[31:0];
      TimerCmpHi:   rdata_d = mtimecmp_q[63:32];
      default:      rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i.valid) begin
      rdata_q <= req_i.we ? '0 : rdata_d;
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
    end
  end

  assign rsp_o       = '{valid: valid_q, err: 1'b0, rdata: rdata_q};
  assign timer_irq_o = mtime_q >= mtimecmp_q;

  // All-ones compare disables the interrupt in practice
  a_irq_disabled: assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni)
    $rose(timer_irq_o) |-> mtimecmp_q != '1
  ) else $error("Timer interrupt raised with compare at all ones");

endmodule

// ==== src/pwm_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// PWM register block
// Period and per-channel duty registers on the bus
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pwm_regs import soc_pkg::*; (
  input  logic                      clk_sys_i,
  input  logic                      rst_sys_ni,

  input  bus_req_t                  req_i,
  output bus_rsp_t                  rsp_o,

  output pwm_cnt_t                  period_o,
  output pwm_cnt_t [PwmWidth-1:0]   duty_o
);

  pwm_cnt_t                period_q;
  pwm_cnt_t [PwmWidth-1:0] duty_q;
  bus_addr_t               offset;
  logic                    wr;
  logic                    valid_q;
  bus_data_t               rdata_d;
  bus_data_t               rdata_q;

  assign offset = req_i.addr & ~PwmMask;
  assign wr     = req_i.valid & req_i.we & req_i.be[0];  // Only the low byte is stored

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      period_q <= '0;
      duty_q   <= '0;
    end else if (wr) begin
      if (offset == PwmPeriodOff) period_q <= req_i.wdata[PwmCtrSize-1:0];
      for (int n = 0; n < PwmWidth; n++) begin
        if (offset == PwmPeriodOff + bus_addr_t'(4 * (n + 1))) begin
          duty_q[n] <= req_i.wdata[PwmCtrSize-1:0];
        end
      end
    end
  end

  // Readback, unused offsets give zero
  always_comb begin
    rdata_d = '0;
    if (offset == PwmPeriodOff) rdata_d = bus_data_t'(period_q);
    for (int n = 0; n < PwmWidth; n++) begin
      if (offset == PwmPeriodOff + bus_addr_t'(4 * (n + 1))) rdata_d = bus_data_t'(duty_q[n]);
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i.valid) begin
      rdata_q <= req_i.we ? '0 : rdata_d;
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
    end
  end

  assign rsp_o    = '{valid: valid_q, err: 1'b0, rdata: rdata_q};
  assign period_o = period_q;
  assign duty_o   = duty_q;

endmodule

// ==== src/pwm_channels.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// PWM channels
// Shared period counter, one duty compare per output
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pwm_channels import soc_pkg::*; (
  input  logic                    clk_sys_i,
  input  logic                    rst_sys_ni,

  input  pwm_cnt_t                period_i,
  input  pwm_cnt_t [PwmWidth-1:0] duty_i,

  output pwm_out_t                pwm_o
);

  pwm_cnt_t ctr_q;
  pwm_out_t pwm_d;
  pwm_out_t pwm_q;

  // Counts 0 .. period, also catches a period lowered below the count
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      ctr_q <= '0;
    end else if (ctr_q >= period_i) begin
      ctr_q <= '0;
    end else begin
      ctr_q <= ctr_q + 1'b1;
    end
  end

  always_comb begin
    for (int n = 0; n < PwmWidth; n++) begin
      pwm_d[n] = ctr_q < duty_i[n];  // Duty above period keeps it high
    end
  end

  // Registered outputs, no glitches at the pins
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      pwm_q <= '0;
    end else begin
      pwm_q <= pwm_d;
    end
  end

  assign pwm_o = pwm_q;

endmodule

// ==== src/demo_soc_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Demo SoC top level
// Host port, interconnect, RAM, timer and PWM
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module demo_soc_top import soc_pkg::*; (
  input  logic     clk_sys_i,
  input  logic     rst_sys_ni,

  input  bus_req_t host_req_i,
  output bus_rsp_t host_rsp_o,

  output logic     timer_irq_o,
  output pwm_out_t pwm_o
);

  bus_req_t dev_req [NrDevices];
  bus_rsp_t dev_rsp [NrDevices];

  // Register block to counter logic
  pwm_cnt_t                pwm_period;
  pwm_cnt_t [PwmWidth-1:0] pwm_duty;

  soc_bus_xbar u_xbar (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .host_req_i (host_req_i),
    .host_rsp_o (host_rsp_o),
    .dev_req_o  (dev_req),
    .dev_rsp_i  (dev_rsp)
  );

  soc_ram u_ram (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (dev_req[DevRam]),
    .rsp_o      (dev_rsp[DevRam])
  );

  soc_timer u_timer (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .req_i       (dev_req[DevTimer]),
    .rsp_o       (dev_rsp[DevTimer]),
    .timer_irq_o (timer_irq_o)
  );

  pwm_regs u_pwm_regs (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (dev_req[DevPwm]),
    .rsp_o      (dev_rsp[DevPwm]),
    .period_o   (pwm_period),
    .duty_o     (pwm_duty)
  );

  pwm_channels u_pwm_channels (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .period_i   (pwm_period),
    .duty_i     (pwm_duty),
    .pwm_o      (pwm_o)
  );

endmodule

// ==== include/tb_bus_tasks.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// Testbench tasks
// Host bus access, result compares and directed tests
// ~~~~~~~~~~~~~~~~~~~~

task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
  check_count++;
  if (exp !== act) begin
    err_count++;
    $display("** Error %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  check_count++;
  if (exp !== act) begin
    err_count++;
    $display("** Error %s: expected %b, actual %b", name, exp, act);
  end
endtask

task automatic check_pwm(input string name, input pwm_cnt_t exp, input pwm_cnt_t act);
  check_count++;
  if (exp !== act) begin
    err_count++;
    $display("** Error %s: expected %0d high cycles, actual %0d", name, exp, act);
  end
endtask

// One request, then wait for the response pulse
task automatic bus_access(input logic we, input bus_addr_t addr, input bus_strb_t be,
                          input bus_data_t wdata, output bus_data_t rdata, output logic err);
  int waited;
  waited = 0;
  @(posedge clk_sys);
  host_req <= '{valid: 1'b1, we: we, addr: addr, be: be, wdata: wdata};
  @(posedge clk_sys);
  host_req.valid <= 1'b0;
  @(negedge clk_sys);  // Response is stable here
  while (!host_rsp.valid && waited < 8) begin
    @(negedge clk_sys);
    waited++;
  end
  if (!host_rsp.valid) begin
    err_count++;
    $display("No response from the DUT to the request at address %h", addr);
  end else if (waited != 0) begin
    err_count++;
    $display("Response to the request at address %h came %0d cycles late", addr, waited);
  end
  rdata = host_rsp.rdata;
  err   = host_rsp.err;
endtask

task automatic bus_write(input bus_addr_t addr, input bus_data_t wdata, input bus_strb_t be,
                         output logic err);
  bus_data_t unused;
  bus_access(1'b1, addr, be, wdata, unused, err);
endtask

task automatic bus_read(input bus_addr_t addr, output bus_data_t rdata, output logic err);
  bus_access(1'b0, addr, 4'hf, '0, rdata, err);
endtask

task automatic test_reset();
  bus_data_t data;
  logic      err;
  @(negedge clk_sys);
  check_flag("test_reset irq", 1'b0, timer_irq);
  for (int n = 0; n < PwmWidth; n++) check_flag("test_reset pwm", 1'b0, pwm[n]);
  for (int r = 0; r <= PwmWidth; r++) begin  // Period plus all duty registers
    bus_read(PwmStart + bus_addr_t'(4 * r), data, err);
    check_data("test_reset reg", '0, data);
    check_flag("test_reset err", 1'b0, err);
  end
endtask

task automatic test_ram();
  bus_data_t model [int];
  int        first_idx;
  int        idx;
  bus_data_t wdata;
  bus_data_t mask;
  bus_data_t data;
  logic      err;
  for (int i = 0; i < 32; i++) begin
    idx   = $urandom_range(MemWords - 1, 0);
    wdata = $urandom;
    if (i == 0) first_idx = idx;
    model[idx] = wdata;
    bus_write(MemStart + bus_addr_t'(4 * idx), wdata, 4'hf, err);
    check_flag("test_ram write err", 1'b0, err);
  end
  // Partial write to bytes 0 and 2
  wdata = $urandom;
  mask  = 32'h00ff_00ff;
  model[first_idx] = (model[first_idx] & ~mask) | (wdata & mask);
  bus_write(MemStart + bus_addr_t'(4 * first_idx), wdata, 4'b0101, err);
  check_flag("test_ram byte write err", 1'b0, err);
  foreach (model[k]) begin
    bus_read(MemStart + bus_addr_t'(4 * k), data, err);
    check_data("test_ram data", model[k], data);
    check_flag("test_ram read err", 1'b0, err);
  end
endtask

task automatic test_unmapped();
  bus_data_t word;
  bus_data_t data;
  logic      err;
  word = $urandom;
  bus_write(MemStart + 32'h14, word, 4'hf, err);
  check_flag("test_unmapped ram write err", 1'b0, err);
  // Same low address bits as the RAM word
  bus_access(1'b1, 32'h4000_0014, 4'hf, ~word, data, err);
  check_flag("test_unmapped write err", 1'b1, err);
  check_data("test_unmapped write data", '0, data);
  bus_read(32'h4000_0014, data, err);
  check_flag("test_unmapped read err", 1'b1, err);
  check_data("test_unmapped read data", '0, data);
  bus_read(32'h8000_1000, data, err);  // Gap below the timer
  check_flag("test_unmapped gap err", 1'b1, err);
  check_data("test_unmapped gap data", '0, data);
  bus_read(MemStart + 32'h14, data, err);
  check_data("test_unmapped ram word", word, data);
  check_flag("test_unmapped ram err", 1'b0, err);
endtask

task automatic test_timer();
  bus_data_t t0;
  bus_data_t t1;
  logic      err;
  bus_write(TimerStart + TimerCmpLo, 32'h0, 4'hf, err);
  bus_write(TimerStart + TimerCmpHi, 32'h1, 4'hf, err);  // Compare at 2**32
  check_flag("test_timer write err", 1'b0, err);
  @(negedge clk_sys);
  check_flag("test_timer irq far", 1'b0, timer_irq);
  bus_read(TimerStart + TimerMtimeLo, t0, err);
  repeat (25) @(posedge clk_sys);
  bus_read(TimerStart + TimerMtimeLo, t1, err);
  check_flag("test_timer read err", 1'b0, err);
  check_flag("test_timer time increases", 1'b1, t1 > t0);
  bus_write(TimerStart + TimerCmpHi, 32'h0, 4'hf, err);
  @(negedge clk_sys);
  check_flag("test_timer irq zero cmp", 1'b1, timer_irq);
  bus_write(TimerStart + TimerCmpLo, 32'hffff_ffff, 4'hf, err);
  bus_write(TimerStart + TimerCmpHi, 32'hffff_ffff, 4'hf, err);
  @(negedge clk_sys);
  check_flag("test_timer irq cleared", 1'b0, timer_irq);
endtask

task automatic test_pwm();
  pwm_cnt_t duty [4];
  pwm_cnt_t high_cnt [4];
  pwm_cnt_t period;
  pwm_cnt_t exp;
  logic     err;
  period = 8'd9;
  duty   = '{8'd0, 8'd5, 8'd10, 8'd3};
  bus_write(PwmStart + PwmPeriodOff, bus_data_t'(period), 4'h1, err);
  for (int n = 0; n < 4; n++) begin
    bus_write(PwmStart + PwmPeriodOff + bus_addr_t'(4 * (n + 1)), bus_data_t'(duty[n]), 4'h1, err);
    check_flag("test_pwm write err", 1'b0, err);
    high_cnt[n] = '0;
  end
  repeat (3) @(negedge clk_sys);
  // One full period of samples
  repeat (int'(period) + 1) begin
    @(negedge clk_sys);
    for (int n = 0; n < 4; n++) begin
      if (pwm[n]) high_cnt[n]++;
    end
  end
  for (int n = 0; n < 4; n++) begin
    exp = (duty[n] < period + 8'd1) ? duty[n] : period + 8'd1;
    check_pwm($sformatf("test_pwm channel %0d", n), exp, high_cnt[n]);
  end
endtask

// ==== test/tb_demo_soc.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Demo SoC testbench
// Clock, reset, timeout and the directed test sequence
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_demo_soc import soc_pkg::*; ();

  localparam int TimeoutCycles = 20000;  // Far above the whole sequence

  logic     clk_sys;
  logic     rst_sys_n;
  bus_req_t host_req;
  bus_rsp_t host_rsp;
  logic     timer_irq;
  pwm_out_t pwm;

  int err_count   = 0;
  int check_count = 0;
  int cycle_count = 0;

  demo_soc_top i_dut (
    .clk_sys_i   (clk_sys),
    .rst_sys_ni  (rst_sys_n),
    .host_req_i  (host_req),
    .host_rsp_o  (host_rsp),
    .timer_irq_o (timer_irq),
    .pwm_o       (pwm)
  );

  // 40 ns period
  always #20 clk_sys = ~clk_sys;

  always @(posedge clk_sys) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout: test sequence still running after %0d cycles", TimeoutCycles);
      $display("Errors found");
      $finish;
    end
  end

  `include "tb_bus_tasks.svh"

  initial begin
    void'($urandom(32'hb239_b476));
    clk_sys   = 1'b0;
    rst_sys_n = 1'b0;
    host_req  = '0;
    repeat (10) @(posedge clk_sys);
    rst_sys_n <= 1'b1;
    @(posedge clk_sys);

    test_reset();
    test_ram();
    test_unmapped();
    test_timer();
    test_pwm();

    $display("Finished: %0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
src/soc_pkg.sv
src/soc_bus_xbar.sv
src/soc_ram.sv
src/soc_timer.sv
src/pwm_regs.sv
src/pwm_channels.sv
src/demo_soc_top.sv
test/tb_demo_soc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the demo SoC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_demo_soc -o tb_demo_soc \
  && sim_out="$(./obj_dir/tb_demo_soc)" \
  && echo "$sim_out" \
  && grep -q "No errors" <<< "$sim_out" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
